// ==== source/kicker_pkg.sv ====
// Layout assumes a 160 KB image with main code, then scroll tiles, then object sprites
`default_nettype none

package kicker_pkg;

    // SDRAM side
    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] sdram_word_t;

    // Host download side
    typedef logic [24:0] ioctl_addr_t;

    // ROM data widths
    typedef logic [7:0]  rom_byte_t;
    typedef logic [31:0] gfx_word_t;

    // Byte offsets inside the downloaded image
    // Main code sits at 0 and runs up to the scroll tiles
    localparam logic [21:0] SCR_START = 22'h01_0000;
    localparam logic [21:0] OBJ_START = 22'h01_8000;
    localparam logic [21:0] ROM_END   = 22'h02_8000;

    // Reader slots, lower index wins arbitration
    localparam int SLOT_MAIN = 0;
    localparam int SLOT_SCR  = 1;
    localparam int SLOT_OBJ  = 2;
    localparam int NUM_SLOTS = 3;

    // Downloader write sequence
    typedef enum logic [0:0] {
        DWNLD_IDLE,
        DWNLD_WAIT_ACK
    } dwnld_state_t;

    // Arbiter read sequence
    // FIRST waits for data_dst, SECOND waits for data_rdy
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_FIRST,
        ARB_SECOND
    } arb_state_t;

endpackage

`default_nettype wire

// ==== source/kicker_dwnld.sv ====
// Host must space ioctl_wr strobes until prog_we falls; bytes past ROM_END pass unchanged
`default_nettype none

module kicker_dwnld (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    downloading,
    input  wire kicker_pkg::ioctl_addr_t ioctl_addr,
    input  wire kicker_pkg::rom_byte_t   ioctl_dout,
    input  wire logic                    ioctl_wr,
    input  wire logic                    sdram_ack,
    output kicker_pkg::sdram_addr_t      prog_addr,
    output kicker_pkg::rom_byte_t        prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we
);

    kicker_pkg::dwnld_state_t state;
    kicker_pkg::ioctl_addr_t  base;
    kicker_pkg::ioctl_addr_t  rel;
    kicker_pkg::ioctl_addr_t  mixed;
    kicker_pkg::ioctl_addr_t  byte_addr;
    logic                     in_scr;
    logic                     in_obj;
    logic                     take;

    // Region decode on the raw host address
    assign in_scr = ioctl_addr >= kicker_pkg::SCR_START && ioctl_addr < kicker_pkg::OBJ_START;
    assign in_obj = ioctl_addr >= kicker_pkg::OBJ_START && ioctl_addr < kicker_pkg::ROM_END;

    // Bit shuffle works on the offset inside the region
    always_comb begin
        base = '0;
        if (in_obj) begin
            base = kicker_pkg::OBJ_START;
        end else if (in_scr) begin
            base = kicker_pkg::SCR_START;
        end
        rel   = ioctl_addr - base;
        mixed = rel;
        if (in_scr) begin
            mixed[0]   = ~rel[3];
            mixed[3:1] = rel[2:0];
        end
        if (in_obj) begin
            mixed[0]   = ~rel[3];
            mixed[1]   = ~rel[4];
            mixed[5:2] = {rel[5], rel[2:0]};
        end
        byte_addr = mixed + base;
    end

    assign take = state == kicker_pkg::DWNLD_IDLE && downloading && ioctl_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= kicker_pkg::DWNLD_IDLE;
        end else begin
            case (state)
                kicker_pkg::DWNLD_IDLE: begin
                    if (take) begin
                        state <= kicker_pkg::DWNLD_WAIT_ACK;
                    end
                end
                kicker_pkg::DWNLD_WAIT_ACK: begin
                    if (sdram_ack) begin
                        state <= kicker_pkg::DWNLD_IDLE;
                    end
                end
                default: begin
                    state <= kicker_pkg::DWNLD_IDLE;
                end
            endcase
        end
    end

    // Write payload held for the whole request
    always_ff @(posedge clk) begin
        if (take) begin
            prog_addr <= byte_addr[22:1];
            prog_data <= ioctl_dout;
            // Active low lane enable, even bytes go to the low lane
            prog_mask <= byte_addr[0] ? 2'b01 : 2'b10;
        end
    end

    assign prog_we = state == kicker_pkg::DWNLD_WAIT_ACK;

    // Host may not send another byte before the SDRAM took the last one
    a_no_wr_while_busy: assert property (
        @(posedge clk) disable iff (rst) prog_we |-> !ioctl_wr
    ) else $error("ioctl_wr strobe while a write is still pending");

endmodule

`default_nettype wire

// ==== source/kicker_rom_slot.sv ====
// DW must be 8 or 32; addr changes during a fetch are picked up only after it completes
`default_nettype none

module kicker_rom_slot #(
    parameter int DW = 8,
    parameter int AW = 16
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    cs,
    input  wire logic [AW-1:0]           addr,
    input  wire logic                    slot_dst,
    input  wire logic                    slot_rdy,
    input  wire kicker_pkg::sdram_word_t word_in,
    output logic [DW-1:0]                data,
    output logic                         ok,
    output logic                         slot_req,
    output kicker_pkg::sdram_addr_t      slot_addr
);

    logic [AW-1:0] tag;
    logic [AW-1:0] req_addr;
    logic          valid;
    logic          hit;
    logic          miss;

    assign hit  = valid && tag == addr;
    assign ok   = cs && hit;
    assign miss = cs && !hit && !slot_req;

    // Word address relative to the region start
    always_comb begin
        if (DW == 8) begin
            // Two bytes per SDRAM word
            slot_addr = kicker_pkg::sdram_addr_t'(req_addr >> 1);
        end else begin
            // Each item spans two words
            slot_addr = kicker_pkg::sdram_addr_t'({req_addr, 1'b0});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= 1'b0;
            slot_req <= 1'b0;
        end else if (slot_req) begin
            if (slot_rdy) begin
                slot_req <= 1'b0;
                valid    <= 1'b1;
            end
        end else if (miss) begin
            slot_req <= 1'b1;
            // Old contents get overwritten during the burst
            valid    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            req_addr <= addr;
        end
        if (slot_rdy) begin
            tag <= req_addr;
        end
    end

    generate
        if (DW == 8) begin : g_byte
            // Only the first word matters, odd bytes sit in the high lane
            always_ff @(posedge clk) begin
                if (slot_dst) begin
                    data <= req_addr[0] ? word_in[15:8] : word_in[7:0];
                end
            end
        end else begin : g_word
            always_ff @(posedge clk) begin
                if (slot_dst) begin
                    data[15:0] <= word_in;
                end
                if (slot_rdy) begin
                    data[DW-1:16] <= word_in;
                end
            end
        end
    endgenerate

    // The arbiter only completes reads that this slot asked for
    a_rdy_needs_req: assert property (
        @(posedge clk) disable iff (rst) slot_rdy |-> slot_req
    ) else $error("slot_rdy without a pending slot_req");

endmodule

`default_nettype wire

// ==== source/kicker_rom_arb.sv ====
// One burst in flight at a time; reads start only while downloading is low
`default_nettype none

module kicker_rom_arb (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              downloading,
    input  wire logic [kicker_pkg::NUM_SLOTS-1:0]  req,
    input  wire kicker_pkg::sdram_addr_t           main_word_addr,
    input  wire kicker_pkg::sdram_addr_t           scr_word_addr,
    input  wire kicker_pkg::sdram_addr_t           obj_word_addr,
    input  wire logic                              sdram_ack,
    input  wire logic                              data_dst,
    input  wire logic                              data_rdy,
    input  wire kicker_pkg::sdram_word_t           data_read,
    output logic [kicker_pkg::NUM_SLOTS-1:0]       dst,
    output logic [kicker_pkg::NUM_SLOTS-1:0]       rdy,
    output kicker_pkg::sdram_word_t                word_out,
    output logic                                   sdram_req,
    output kicker_pkg::sdram_addr_t                sdram_addr
);

    kicker_pkg::arb_state_t                state;
    logic [kicker_pkg::NUM_SLOTS-1:0]      grant;
    logic [kicker_pkg::NUM_SLOTS-1:0]      pick;
    kicker_pkg::sdram_addr_t               pick_addr;
    logic                                  start;

    // Fixed priority, main code first
    always_comb begin
        pick      = '0;
        pick_addr = main_word_addr;
        if (req[kicker_pkg::SLOT_MAIN]) begin
            pick[kicker_pkg::SLOT_MAIN] = 1'b1;
        end else if (req[kicker_pkg::SLOT_SCR]) begin
            pick[kicker_pkg::SLOT_SCR] = 1'b1;
            pick_addr = scr_word_addr + (kicker_pkg::SCR_START >> 1);
        end else if (req[kicker_pkg::SLOT_OBJ]) begin
            pick[kicker_pkg::SLOT_OBJ] = 1'b1;
            pick_addr = obj_word_addr + (kicker_pkg::OBJ_START >> 1);
        end
    end

    assign start = state == kicker_pkg::ARB_IDLE && !downloading && |req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= kicker_pkg::ARB_IDLE;
            grant <= '0;
        end else begin
            case (state)
                kicker_pkg::ARB_IDLE: begin
                    if (start) begin
                        grant <= pick;
                        state <= kicker_pkg::ARB_WAIT_ACK;
                    end
                end
                kicker_pkg::ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        state <= kicker_pkg::ARB_FIRST;
                    end
                end
                kicker_pkg::ARB_FIRST: begin
                    if (data_dst) begin
                        state <= kicker_pkg::ARB_SECOND;
                    end
                end
                kicker_pkg::ARB_SECOND: begin
                    if (data_rdy) begin
                        grant <= '0;
                        state <= kicker_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= kicker_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= pick_addr;
        end
    end

    assign sdram_req = state == kicker_pkg::ARB_WAIT_ACK;

    // Burst strobes reach the granted reader only
    assign dst      = (state == kicker_pkg::ARB_FIRST && data_dst) ? grant : '0;
    assign rdy      = (state == kicker_pkg::ARB_SECOND && data_rdy) ? grant : '0;
    assign word_out = data_read;

    // A pending read and a download would both claim the shared sdram_ack
    a_no_read_in_dwnld: assert property (
        @(posedge clk) disable iff (rst) sdram_req |-> !downloading
    ) else $error("downloading rose while a read request was pending");

endmodule

`default_nettype wire

// ==== source/kicker_rom.sv ====
// Download and reads must not overlap since both share sdram_ack
`default_nettype none

module kicker_rom (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // Host download
    input  wire logic                    downloading,
    input  wire kicker_pkg::ioctl_addr_t ioctl_addr,
    input  wire kicker_pkg::rom_byte_t   ioctl_dout,
    input  wire logic                    ioctl_wr,
    // SDRAM
    input  wire logic                    sdram_ack,
    input  wire kicker_pkg::sdram_word_t data_read,
    input  wire logic                    data_dst,
    input  wire logic                    data_rdy,
    // Main CPU code
    input  wire logic                    main_cs,
    input  wire logic [15:0]             main_addr,
    output kicker_pkg::rom_byte_t        main_data,
    output logic                         main_ok,
    // Scroll tiles
    input  wire logic                    scr_cs,
    input  wire logic [12:0]             scr_addr,
    output kicker_pkg::gfx_word_t        scr_data,
    output logic                         scr_ok,
    // Object sprites
    input  wire logic                    obj_cs,
    input  wire logic [13:0]             obj_addr,
    output kicker_pkg::gfx_word_t        obj_data,
    output logic                         obj_ok,
    // SDRAM write and read requests
    output kicker_pkg::sdram_addr_t      prog_addr,
    output kicker_pkg::rom_byte_t        prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we,
    output logic                         sdram_req,
    output kicker_pkg::sdram_addr_t      sdram_addr
);

    logic [kicker_pkg::NUM_SLOTS-1:0] slot_req;
    logic [kicker_pkg::NUM_SLOTS-1:0] slot_dst;
    logic [kicker_pkg::NUM_SLOTS-1:0] slot_rdy;
    kicker_pkg::sdram_addr_t          main_word_addr;
    kicker_pkg::sdram_addr_t          scr_word_addr;
    kicker_pkg::sdram_addr_t          obj_word_addr;
    kicker_pkg::sdram_word_t          word_bus;

    kicker_dwnld u_dwnld (
        .clk         ( clk          ),
        .rst         ( rst          ),
        .downloading ( downloading  ),
        .ioctl_addr  ( ioctl_addr   ),
        .ioctl_dout  ( ioctl_dout   ),
        .ioctl_wr    ( ioctl_wr     ),
        .sdram_ack   ( sdram_ack    ),
        .prog_addr   ( prog_addr    ),
        .prog_data   ( prog_data    ),
        .prog_mask   ( prog_mask    ),
        .prog_we     ( prog_we      )
    );

    kicker_rom_slot #(.DW(8), .AW(16)) u_main_slot (
        .clk       ( clk                                  ),
        .rst       ( rst                                  ),
        .cs        ( main_cs                              ),
        .addr      ( main_addr                            ),
        .slot_dst  ( slot_dst[kicker_pkg::SLOT_MAIN]      ),
        .slot_rdy  ( slot_rdy[kicker_pkg::SLOT_MAIN]      ),
        .word_in   ( word_bus                             ),
        .data      ( main_data                            ),
        .ok        ( main_ok                              ),
        .slot_req  ( slot_req[kicker_pkg::SLOT_MAIN]      ),
        .slot_addr ( main_word_addr                       )
    );

    kicker_rom_slot #(.DW(32), .AW(13)) u_scr_slot (
        .clk       ( clk                                  ),
        .rst       ( rst                                  ),
        .cs        ( scr_cs                               ),
        .addr      ( scr_addr                             ),
        .slot_dst  ( slot_dst[kicker_pkg::SLOT_SCR]       ),
        .slot_rdy  ( slot_rdy[kicker_pkg::SLOT_SCR]       ),
        .word_in   ( word_bus                             ),
        .data      ( scr_data                             ),
        .ok        ( scr_ok                               ),
        .slot_req  ( slot_req[kicker_pkg::SLOT_SCR]       ),
        .slot_addr ( scr_word_addr                        )
    );

    kicker_rom_slot #(.DW(32), .AW(14)) u_obj_slot (
        .clk       ( clk                                  ),
        .rst       ( rst                                  ),
        .cs        ( obj_cs                               ),
        .addr      ( obj_addr                             ),
        .slot_dst  ( slot_dst[kicker_pkg::SLOT_OBJ]       ),
        .slot_rdy  ( slot_rdy[kicker_pkg::SLOT_OBJ]       ),
        .word_in   ( word_bus                             ),
        .data      ( obj_data                             ),
        .ok        ( obj_ok                               ),
        .slot_req  ( slot_req[kicker_pkg::SLOT_OBJ]       ),
        .slot_addr ( obj_word_addr                        )
    );

    kicker_rom_arb u_arb (
        .clk            ( clk            ),
        .rst            ( rst            ),
        .downloading    ( downloading    ),
        .req            ( slot_req       ),
        .main_word_addr ( main_word_addr ),
        .scr_word_addr  ( scr_word_addr  ),
        .obj_word_addr  ( obj_word_addr  ),
        .sdram_ack      ( sdram_ack      ),
        .data_dst       ( data_dst       ),
        .data_rdy       ( data_rdy       ),
        .data_read      ( data_read      ),
        .dst            ( slot_dst       ),
        .rdy            ( slot_rdy       ),
        .word_out       ( word_bus       ),
        .sdram_req      ( sdram_req      ),
        .sdram_addr     ( sdram_addr     )
    );

endmodule

`default_nettype wire

// ==== testbench/kicker_clk_gen.sv ====
// Free-running clock with period 8 and reset held high for the first two rising edges
`default_nettype none

module kicker_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Released just after the second rising edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/kicker_sdram_model.sv ====
// Answers after 0 to 3 idle cycles; words that were never written read back as X
`default_nettype none

module kicker_sdram_model (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire kicker_pkg::sdram_addr_t prog_addr,
    input  wire kicker_pkg::rom_byte_t   prog_data,
    input  wire logic [1:0]              prog_mask,
    input  wire logic                    prog_we,
    input  wire logic                    sdram_req,
    input  wire kicker_pkg::sdram_addr_t sdram_addr,
    output logic                         sdram_ack,
    output kicker_pkg::sdram_word_t      data_read,
    output logic                         data_dst,
    output logic                         data_rdy
);

    kicker_pkg::sdram_word_t mem [0:(kicker_pkg::ROM_END >> 1) - 1];
    kicker_pkg::sdram_addr_t rd_addr;
    logic [15:0]             lfsr;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Idle for a random count of falling edges, two LFSR bits per gap
    task automatic random_gap();
        int gap;
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            gap = gap * 2 + lfsr[0];
        end
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        lfsr      = 16'd55;
        sdram_ack = 1'b0;
        data_read = '0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
    end

    always begin
        @(negedge clk);
        if (!rst && prog_we) begin
            random_gap();
            // Mask is active low, one lane per byte
            if (!prog_mask[0]) begin
                mem[prog_addr][7:0] = prog_data;
            end
            if (!prog_mask[1]) begin
                mem[prog_addr][15:8] = prog_data;
            end
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
        end else if (!rst && sdram_req) begin
            rd_addr = sdram_addr;
            random_gap();
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
            // Two-word burst at rd_addr and the word after it
            random_gap();
            data_read = mem[rd_addr];
            data_dst  = 1'b1;
            @(negedge clk);
            data_dst  = 1'b0;
            random_gap();
            data_read = mem[rd_addr + 1];
            data_rdy  = 1'b1;
            @(negedge clk);
            data_rdy  = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/kicker_tb.sv ====
// Downloads and reads back only the first 1 KB of each region
`default_nettype none

module kicker_tb;

    logic                    clk;
    logic                    rst;
    logic                    downloading;
    kicker_pkg::ioctl_addr_t ioctl_addr;
    kicker_pkg::rom_byte_t   ioctl_dout;
    logic                    ioctl_wr;
    logic                    sdram_ack;
    kicker_pkg::sdram_word_t data_read;
    logic                    data_dst;
    logic                    data_rdy;
    logic                    main_cs;
    logic [15:0]             main_addr;
    kicker_pkg::rom_byte_t   main_data;
    logic                    main_ok;
    logic                    scr_cs;
    logic [12:0]             scr_addr;
    kicker_pkg::gfx_word_t   scr_data;
    logic                    scr_ok;
    logic                    obj_cs;
    logic [13:0]             obj_addr;
    kicker_pkg::gfx_word_t   obj_data;
    logic                    obj_ok;
    kicker_pkg::sdram_addr_t prog_addr;
    kicker_pkg::rom_byte_t   prog_data;
    logic [1:0]              prog_mask;
    logic                    prog_we;
    logic                    sdram_req;
    kicker_pkg::sdram_addr_t sdram_addr;

    // Expected SDRAM contents in byte order, after reordering
    logic [7:0]  stored [0:kicker_pkg::ROM_END-1];
    logic [15:0] lfsr;
    int          errors;
    int          timeouts;
    int          n;
    int          s;
    int          i;
    int          last_addr [0:2];
    int          miss_addr [0:2];
    logic [31:0] v;

    kicker_clk_gen u_clk_gen (
        .clk ( clk ),
        .rst ( rst )
    );

    kicker_rom dut0 (.*);

    kicker_sdram_model u_sdram (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] st);
        return {st[14:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        int k;
        value = '0;
        for (k = 0; k < count; k++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic kicker_pkg::ioctl_addr_t region_base(input int slot);
        case (slot)
            kicker_pkg::SLOT_MAIN: return '0;
            kicker_pkg::SLOT_SCR:  return kicker_pkg::SCR_START;
            default:               return kicker_pkg::OBJ_START;
        endcase
    endfunction

    // Host byte address to the byte position it lands on in SDRAM
    function automatic kicker_pkg::ioctl_addr_t reorder_addr(input kicker_pkg::ioctl_addr_t a);
        kicker_pkg::ioctl_addr_t r;
        r = a;
        if (a >= kicker_pkg::OBJ_START && a < kicker_pkg::ROM_END) begin
            r = a - kicker_pkg::OBJ_START;
            r = {r[24:6], r[5], r[2:0], ~r[4], ~r[3]} + kicker_pkg::OBJ_START;
        end else if (a >= kicker_pkg::SCR_START && a < kicker_pkg::OBJ_START) begin
            r = a - kicker_pkg::SCR_START;
            r = {r[24:4], r[2:0], ~r[3]} + kicker_pkg::SCR_START;
        end
        return r;
    endfunction

    // Graphics items are four bytes, lowest byte first
    function automatic logic [31:0] expected_item(input int slot, input int a);
        int b;
        if (slot == kicker_pkg::SLOT_MAIN) begin
            return {24'd0, stored[a]};
        end
        b = region_base(slot) + a * 4;
        return {stored[b + 3], stored[b + 2], stored[b + 1], stored[b]};
    endfunction

    function automatic logic [31:0] actual_item(input int slot);
        case (slot)
            kicker_pkg::SLOT_MAIN: return {24'd0, main_data};
            kicker_pkg::SLOT_SCR:  return scr_data;
            default:               return obj_data;
        endcase
    endfunction

    function automatic logic item_ok(input int slot);
        case (slot)
            kicker_pkg::SLOT_MAIN: return main_ok;
            kicker_pkg::SLOT_SCR:  return scr_ok;
            default:               return obj_ok;
        endcase
    endfunction

    function automatic string slot_name(input int slot);
        case (slot)
            kicker_pkg::SLOT_MAIN: return "main_data";
            kicker_pkg::SLOT_SCR:  return "scr_data";
            default:               return "obj_data";
        endcase
    endfunction

    function automatic string ok_name(input int slot);
        case (slot)
            kicker_pkg::SLOT_MAIN: return "main_ok";
            kicker_pkg::SLOT_SCR:  return "scr_ok";
            default:               return "obj_ok";
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic check_quiet();
        if (main_ok !== 1'b0) report_mismatch("main_ok", 0, main_ok);
        if (scr_ok !== 1'b0) report_mismatch("scr_ok", 0, scr_ok);
        if (obj_ok !== 1'b0) report_mismatch("obj_ok", 0, obj_ok);
        if (sdram_req !== 1'b0) report_mismatch("sdram_req", 0, sdram_req);
        if (prog_we !== 1'b0) report_mismatch("prog_we", 0, prog_we);
    endtask

    // One host byte, checked against the reordering rule
    task automatic write_byte(input kicker_pkg::ioctl_addr_t a, input kicker_pkg::rom_byte_t d);
        kicker_pkg::ioctl_addr_t r;
        logic [1:0]              mask_exp;
        int                      cnt;
        r = reorder_addr(a);
        mask_exp = ~(2'b01 << r[0]);
        stored[r] = d;
        if (prog_we !== 1'b0) report_mismatch("prog_we", 0, prog_we);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (prog_we !== 1'b1) report_mismatch("prog_we", 1, prog_we);
        if (prog_addr !== r[22:1]) report_mismatch("prog_addr", r[22:1], prog_addr);
        if (prog_mask !== mask_exp) report_mismatch("prog_mask", mask_exp, prog_mask);
        if (prog_data !== d) report_mismatch("prog_data", d, prog_data);
        cnt = 0;
        while (prog_we === 1'b1 && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        if (prog_we === 1'b1) begin
            timeouts++;
            $display("Timeout: SDRAM never acknowledged the write of host byte %h", a);
        end
    endtask

    task automatic start_read(input int slot, input int a);
        last_addr[slot] = a;
        case (slot)
            kicker_pkg::SLOT_MAIN: begin
                main_cs = 1'b1;
                main_addr = a[15:0];
            end
            kicker_pkg::SLOT_SCR: begin
                scr_cs = 1'b1;
                scr_addr = a[12:0];
            end
            default: begin
                obj_cs = 1'b1;
                obj_addr = a[13:0];
            end
        endcase
    endtask

    task automatic finish_read(input int slot, input int a);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (item_ok(slot) !== 1'b1 && cnt < 200) begin
            @(negedge clk);
            cnt++;
        end
        if (item_ok(slot) !== 1'b1) begin
            timeouts++;
            $display("Timeout: %s never became valid for address %0d", slot_name(slot), a);
        end else if (actual_item(slot) !== expected_item(slot, a)) begin
            report_mismatch(slot_name(slot), expected_item(slot, a), actual_item(slot));
        end
    endtask

    initial begin
        lfsr = 16'd55;
        errors = 0;
        timeouts = 0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr = 1'b0;
        main_cs = 1'b0;
        main_addr = '0;
        scr_cs = 1'b0;
        scr_addr = '0;
        obj_cs = 1'b0;
        obj_addr = '0;
        for (s = 0; s < 3; s++) begin
            last_addr[s] = 0;
        end
        n = 0;
        @(negedge clk);
        while (rst !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        // Misses queue up while downloading and no cache holds data yet
        downloading = 1'b1;
        for (s = 0; s < 3; s++) begin
            start_read(s, 0);
        end
        repeat (4) begin
            check_quiet();
            @(negedge clk);
        end

        for (s = 0; s < 3; s++) begin
            for (i = 0; i < 1024; i++) begin
                random_bits(8, v);
                write_byte(region_base(s) + i, v[7:0]);
            end
        end
        downloading = 1'b0;

        // Queued misses are served once the download ends
        for (s = 0; s < 3; s++) begin
            finish_read(s, 0);
        end

        // Random single reads across the three readers
        repeat (60) begin
            random_bits(2, v);
            s = v % 3;
            random_bits(s == kicker_pkg::SLOT_MAIN ? 10 : 8, v);
            start_read(s, v);
            finish_read(s, v);
        end

        // Three misses in one cycle, main has the highest priority
        for (s = 0; s < 3; s++) begin
            random_bits(s == kicker_pkg::SLOT_MAIN ? 10 : 8, v);
            miss_addr[s] = (v == last_addr[s]) ? v ^ 1 : v;
        end
        for (s = 0; s < 3; s++) begin
            start_read(s, miss_addr[s]);
        end
        n = 0;
        @(negedge clk);
        while (sdram_req !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (sdram_req !== 1'b1) begin
            timeouts++;
            $display("Timeout: no SDRAM read request after three simultaneous misses");
        end else if (sdram_addr !== miss_addr[kicker_pkg::SLOT_MAIN] >> 1) begin
            report_mismatch("sdram_addr", miss_addr[kicker_pkg::SLOT_MAIN] >> 1, sdram_addr);
        end
        for (s = 0; s < 3; s++) begin
            finish_read(s, miss_addr[s]);
        end

        // Held addresses must hit without touching the SDRAM
        repeat (20) begin
            @(negedge clk);
            if (sdram_req !== 1'b0) report_mismatch("sdram_req", 0, sdram_req);
            for (s = 0; s < 3; s++) begin
                if (item_ok(s) !== 1'b1) report_mismatch(ok_name(s), 1, item_ok(s));
                if (actual_item(s) !== expected_item(s, miss_addr[s])) begin
                    report_mismatch(slot_name(s), expected_item(s, miss_addr[s]),
                                    actual_item(s));
                end
            end
        end

        $display("Mismatches: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/kicker_pkg.sv
source/kicker_dwnld.sv
source/kicker_rom_slot.sv
source/kicker_rom_arb.sv
source/kicker_rom.sv
testbench/kicker_clk_gen.sv
testbench/kicker_sdram_model.sv
testbench/kicker_tb.sv
